// ==== src/fifo_geom_pkg.sv ====
package fifo_geom_pkg;

  // --------------------------------------------------
  // Storage geometry
  // --------------------------------------------------

  // Number of storage slots
  localparam int Depth = 8;

  // Bits per data word
  localparam int Width = 16;

  // Slot address bits
  localparam int AddrWidth = $clog2(Depth);

  // Enough bits to hold 0 through Depth inclusive
  localparam int CountWidth = $clog2(Depth + 1);

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  typedef logic [Width-1:0]      data_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [CountWidth-1:0] count_t;

endpackage

// ==== src/fifo_flow_pkg.sv ====
package fifo_flow_pkg;

  // Credit pool size follows the storage depth
  import fifo_geom_pkg::*;

  // --------------------------------------------------
  // Credit flow control
  // --------------------------------------------------

  // Wide enough to hold Depth credits
  localparam int CreditWidth = $clog2(Depth + 1);

  // Credit count on either side of the push interface
  typedef logic [CreditWidth-1:0] credit_t;

endpackage

// ==== src/fifo_ram.sv ====
`timescale 1ns/1ps

module fifo_ram import fifo_geom_pkg::*; (
  input  logic  clk,

  // Write port
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,

  // Read port, zero latency
  input  addr_t rd_addr,
  output data_t rd_data
);

  // --------------------------------------------------
  // Storage array
  // --------------------------------------------------

  // Payload only, contents are don't care until written
  data_t mem [Depth];

  // Synchronous write
  // New word visible to the read port on the next cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  // Combinational read of the addressed slot
  // Same-slot write this cycle still returns the old word
  assign rd_data = mem[rd_addr];

endmodule

// ==== src/fifo_push_ctrl.sv ====
`timescale 1ns/1ps

module fifo_push_ctrl import fifo_geom_pkg::*, fifo_flow_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  // Credit-based push side
  input  logic  push_valid,
  input  data_t push_data,
  output logic  credit_return,

  // Bypass offer towards the pop controller
  output logic  bypass_valid,
  output data_t bypass_data,
  input  logic  bypass_ready,

  // Handshakes shared with the pop controller
  output logic  ram_push,
  input  logic  ram_pop,

  // Storage write port
  output logic  wr_en,
  output addr_t wr_addr,
  output data_t wr_data,

  // Sticky error flag
  output logic  overflow
);

  // --------------------------------------------------
  // Push steering
  // --------------------------------------------------

  // Free slots in storage
  credit_t slots;

  // Push that cannot go through the bypass path
  logic    need_store;
  logic    drop;
  logic    bypass_taken;

  // Every push is offered to the pop side first
  assign bypass_valid = push_valid;
  assign bypass_data  = push_data;
  assign bypass_taken = push_valid && bypass_ready;

  // Not taken by bypass, so it must land in storage
  assign need_store = push_valid && !bypass_ready;
  assign ram_push   = need_store && (slots != '0);
  // No room left, word is lost
  assign drop       = need_store && (slots == '0);

  assign wr_en   = ram_push;
  assign wr_data = push_data;

  // --------------------------------------------------
  // Write address
  // --------------------------------------------------

  // Wraps at Depth so a non power of two depth also works
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr <= '0;
    end else if (ram_push) begin
      if (wr_addr == addr_t'(Depth - 1)) wr_addr <= '0;
      else wr_addr <= wr_addr + 1'b1;
    end
  end

  // --------------------------------------------------
  // Slot tracking and credit return
  // --------------------------------------------------

  // Starts full of free slots, simultaneous push and pop cancel
  always_ff @(posedge clk) begin
    if (rst) begin
      slots <= credit_t'(Depth);
    end else if (ram_push && !ram_pop) begin
      slots <= slots - 1'b1;
    end else if (!ram_push && ram_pop) begin
      slots <= slots + 1'b1;
    end
  end

  // One pulse per word leaving the FIFO, one cycle late
  // Bypass and storage pops are exclusive in a cycle
  always_ff @(posedge clk) begin
    if (rst) credit_return <= 1'b0;
    else credit_return <= ram_pop || bypass_taken;
  end

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (rst) overflow <= 1'b0;
    else if (drop) overflow <= 1'b1;
  end

endmodule

// ==== src/fifo_pop_ctrl.sv ====
`timescale 1ns/1ps

module fifo_pop_ctrl import fifo_geom_pkg::*; (
  input  logic   clk,
  input  logic   rst,

  // Ready/valid pop side
  input  logic   pop_ready,
  output logic   pop_valid,
  output data_t  pop_data,

  // Bypass offer from the push controller
  input  logic   bypass_valid,
  input  data_t  bypass_data,
  output logic   bypass_ready,

  // Storage read port
  output addr_t  rd_addr,
  input  data_t  rd_data,

  // Handshakes shared with the push controller
  input  logic   ram_push,
  output logic   ram_pop,

  // Status
  output logic   empty,
  output count_t items
);

  // --------------------------------------------------
  // Pop handshake
  // --------------------------------------------------

  logic   pop;
  count_t items_next;
  logic   empty_next;

  assign pop = pop_valid && pop_ready;

  // Bypass only while storage holds nothing
  assign bypass_ready = empty && pop_ready;

  // Head of storage, or the live push when empty
  // In bypass, valid follows the sender directly
  assign pop_valid = !empty || bypass_valid;
  assign pop_data  = empty ? bypass_data : rd_data;

  // Only non-bypass pops consume a stored word
  assign ram_pop = pop && !empty;

  // --------------------------------------------------
  // Read address
  // --------------------------------------------------

  // Points at the oldest stored word
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (ram_pop) begin
      if (rd_addr == addr_t'(Depth - 1)) rd_addr <= '0;
      else rd_addr <= rd_addr + 1'b1;
    end
  end

  // --------------------------------------------------
  // Item count
  // --------------------------------------------------

  // Push and pop together leave the count unchanged
  always_comb begin
    items_next = items;
    if (ram_push && !ram_pop) items_next = items + 1'b1;
    else if (!ram_push && ram_pop) items_next = items - 1'b1;
  end

  assign empty_next = (items_next == '0);

  // Load only on storage activity
  // Bypassed words never touch these
  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
      empty <= 1'b1;
    end else if (ram_push || ram_pop) begin
      items <= items_next;
      empty <= empty_next;
    end
  end

endmodule

// ==== src/fifo_credit_top.sv ====
`timescale 1ns/1ps

module fifo_credit_top import fifo_geom_pkg::*; (
  input  logic   clk,
  input  logic   rst,

  // Credit-based push side
  input  logic   push_valid,
  input  data_t  push_data,
  output logic   credit_return,

  // Ready/valid pop side
  input  logic   pop_ready,
  output logic   pop_valid,
  output data_t  pop_data,

  // Status
  output logic   empty,
  output count_t items,
  output logic   overflow
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  // Bypass path
  logic  bypass_valid;
  data_t bypass_data;
  logic  bypass_ready;

  // Storage activity
  logic  ram_push;
  logic  ram_pop;

  // Storage ports
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;
  addr_t rd_addr;
  data_t rd_data;

  // Input side
  fifo_push_ctrl u_push (
    .clk, .rst,
    .push_valid, .push_data, .credit_return,
    .bypass_valid, .bypass_data, .bypass_ready,
    .ram_push, .ram_pop,
    .wr_en, .wr_addr, .wr_data,
    .overflow
  );

  // Flop storage
  fifo_ram u_ram (
    .clk,
    .wr_en, .wr_addr, .wr_data,
    .rd_addr, .rd_data
  );

  // Output side
  fifo_pop_ctrl u_pop (
    .clk, .rst,
    .pop_ready, .pop_valid, .pop_data,
    .bypass_valid, .bypass_data, .bypass_ready,
    .rd_addr, .rd_data,
    .ram_push, .ram_pop,
    .empty, .items
  );

endmodule

// ==== sim/fifo_checker.sv ====
`timescale 1ns/1ps

module fifo_checker import fifo_geom_pkg::*; (
  input logic   clk,
  input logic   rst,

  // Push side as seen at the DUT
  input logic   push_valid,
  input data_t  push_data,
  input logic   credit_return,

  // Pop side as seen at the DUT
  input logic   pop_ready,
  input logic   pop_valid,
  input data_t  pop_data,

  // Status
  input logic   empty,
  input count_t items,
  input logic   overflow
);

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------

  // Words held in storage, oldest first
  data_t model_q [$];

  // Credit pulse owed for last cycle's pop
  logic  credit_due;

  // Set once a push was dropped
  logic  overflow_seen;

  // Counters read by the testbench top
  int    errors;
  int    pops;
  int    credits_seen;

  initial begin
    errors = 0;
    pops = 0;
    credits_seen = 0;
    credit_due = 1'b0;
    overflow_seen = 1'b0;
  end

  // Word expected on pop_data
  // Stored head, or the live push when storage is empty
  function automatic data_t expected_head(input data_t live);
    if (model_q.size() != 0) return model_q[0];
    return live;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, act);
    errors++;
  endtask

  // --------------------------------------------------
  // Compare and advance, once per cycle
  // --------------------------------------------------

  // Mid-cycle sampling, all ports settled by now
  always @(negedge clk) begin
    int   size_before;
    logic exp_valid;
    logic bypass;
    logic pop;
    if (rst) begin
      model_q.delete();
      credit_due = 1'b0;
      overflow_seen = 1'b0;
    end else begin
      size_before = model_q.size();

      // Registered outputs reflect last cycle's activity
      if (credit_return !== credit_due) flag_mismatch("credit_return", credit_due, credit_return);
      if (credit_return === 1'b1) credits_seen++;
      if (overflow !== overflow_seen) flag_mismatch("overflow", overflow_seen, overflow);
      if (items !== count_t'(size_before)) flag_mismatch("items", size_before, items);
      if (empty !== (size_before == 0)) flag_mismatch("empty", size_before == 0, empty);

      // Combinational pop side
      exp_valid = (size_before != 0) || push_valid;
      bypass = (size_before == 0) && pop_ready && push_valid;
      if (pop_valid !== exp_valid) flag_mismatch("pop_valid", exp_valid, pop_valid);
      if (exp_valid && pop_data !== expected_head(push_data)) begin
        flag_mismatch("pop_data", expected_head(push_data), pop_data);
      end

      // Handshake at the coming edge
      pop = exp_valid && pop_ready;
      credit_due = pop;
      if (pop) begin
        pops++;
        if (!bypass) void'(model_q.pop_front());
      end

      // Free slots judged before this cycle's pop
      if (push_valid && !bypass) begin
        if (size_before == Depth) overflow_seen = 1'b1;
        else model_q.push_back(push_data);
      end
    end
  end

endmodule

// ==== sim/fifo_tb.sv ====
`timescale 1ns/1ps

module fifo_tb import fifo_geom_pkg::*, fifo_flow_pkg::*; ();

  logic    clk;
  logic    rst;
  logic    push_valid;
  data_t   push_data;
  logic    pop_ready;
  logic    credit_return;
  logic    pop_valid;
  data_t   pop_data;
  logic    empty;
  count_t  items;
  logic    overflow;

  // Sender model
  credit_t credits;
  int      pushes;
  logic    forced_push;

  // Run bookkeeping
  int      local_errors;
  int      tests_run;
  int      tests_failed;
  int      last_errors;
  logic    timed_out;

  fifo_credit_top UUT (
    .clk, .rst,
    .push_valid, .push_data, .credit_return,
    .pop_ready, .pop_valid, .pop_data,
    .empty, .items, .overflow
  );

  fifo_checker u_checker (
    .clk, .rst,
    .push_valid, .push_data, .credit_return,
    .pop_ready, .pop_valid, .pop_data,
    .empty, .items, .overflow
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Sender credit count
  // --------------------------------------------------

  // One credit per push
  // One credit back per pulse
  // Forced push bypasses the credit rule
  always @(negedge clk) begin
    if (rst) begin
      credits = credit_t'(Depth);
      pushes = 0;
    end else begin
      if (push_valid && !forced_push) begin
        credits = credits - 1'b1;
        pushes++;
      end
      if (credit_return) credits = credits + 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, act);
      local_errors++;
    end
  endtask

  // Drive 2 ns after the edge
  // Push only with credit left
  task automatic send_cycle(input logic want_push, input data_t data, input logic ready);
    @(posedge clk);
    #2;
    push_valid = want_push && (credits != '0);
    push_data  = data;
    pop_ready  = ready;
  endtask

  // Just after negedge once the counters have moved
  task automatic sample_point();
    @(negedge clk);
    #1;
  endtask

  task automatic report_test(input string name);
    int total;
    total = local_errors + u_checker.errors;
    tests_run++;
    if (total != last_errors) begin
      tests_failed++;
      $display("FAIL  %s", name);
    end else begin
      $display("PASS  %s", name);
    end
    last_errors = total;
  endtask

  // Pop until storage is empty
  // One idle cycle more lets the last credit pulse land
  task automatic drain_and_settle(input int limit, input string what);
    int n;
    n = 0;
    do begin
      send_cycle(1'b0, '0, 1'b1);
      sample_point();
      n++;
    end while (!empty && n < limit);
    if (!empty) begin
      $display("Timeout while %s, FIFO never went empty", what);
      timed_out = 1'b1;
    end else begin
      send_cycle(1'b0, '0, 1'b1);
      sample_point();
    end
  endtask

  // Back-pressured pushes of counting data until credits run out
  task automatic fill_until_no_credit(input int limit, input data_t base);
    int n;
    n = 0;
    while (credits != '0 && n < limit) begin
      send_cycle(1'b1, base + data_t'(n), 1'b0);
      sample_point();
      n++;
    end
    send_cycle(1'b0, '0, 1'b0);
    sample_point();
    if (credits != '0) begin
      $display("Timeout while filling, sender never ran out of credits");
      timed_out = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  task automatic run_tests();
    int    i;
    int    credit_mark;
    int    pop_mark;
    data_t word;

    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    sample_point();
    check_value("credit_return", 0, credit_return);
    check_value("overflow", 0, overflow);
    check_value("pop_valid", 0, pop_valid);
    check_value("items", 0, items);
    check_value("empty", 1, empty);
    report_test("reset state");

    // Random traffic
    // Ordering checked by u_checker
    for (i = 0; i < 400; i++) begin
      send_cycle(($urandom % 100) < 70, data_t'($urandom), ($urandom % 100) < 60);
    end
    sample_point();
    report_test("random ordering");

    drain_and_settle(200, "draining before bypass");
    if (timed_out) return;
    word = data_t'($urandom);
    send_cycle(1'b1, word, 1'b1);
    sample_point();
    check_value("pop_valid", 1, pop_valid);
    check_value("pop_data", word, pop_data);
    send_cycle(1'b0, '0, 1'b1);
    sample_point();
    check_value("items", 0, items);
    check_value("empty", 1, empty);
    report_test("bypass");

    drain_and_settle(20, "draining after bypass");
    if (timed_out) return;
    credit_mark = u_checker.credits_seen;
    fill_until_no_credit(Depth + 20, 16'h4000);
    if (timed_out) return;
    check_value("items", Depth, items);
    check_value("overflow", 0, overflow);
    check_value("credit pulses during fill", credit_mark, u_checker.credits_seen);
    pop_mark = u_checker.pops;
    drain_and_settle(Depth + 20, "draining after fill");
    if (timed_out) return;
    check_value("words drained", pop_mark + Depth, u_checker.pops);
    report_test("fill and drain");

    check_value("credit pulses vs pushes", pushes, u_checker.credits_seen);
    check_value("sender credits", Depth, credits);
    report_test("credit conservation");

    // Full storage then one push with no credit behind it
    fill_until_no_credit(Depth + 20, 16'h0100);
    if (timed_out) return;
    word = 16'hffff;
    @(posedge clk);
    #2;
    forced_push = 1'b1;
    push_valid = 1'b1;
    push_data = word;
    pop_ready = 1'b0;
    send_cycle(1'b0, '0, 1'b0);
    forced_push = 1'b0;
    sample_point();
    check_value("overflow", 1, overflow);
    pop_mark = u_checker.pops;
    i = 0;
    do begin
      send_cycle(1'b0, '0, 1'b1);
      sample_point();
      check_value("overflow", 1, overflow);
      if (pop_valid && pop_data == word) begin
        $display("Dropped word %h showed up on pop_data at t=%0t", word, $time);
        local_errors++;
      end
      i++;
    end while (!empty && i < Depth + 20);
    if (!empty) begin
      $display("Timeout while draining after overflow, FIFO never went empty");
      timed_out = 1'b1;
      return;
    end
    check_value("words drained", pop_mark + Depth, u_checker.pops);
    report_test("overflow");
  endtask

  initial begin
    int total;
    rst = 1'b1;
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    forced_push = 1'b0;
    local_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    last_errors = 0;
    timed_out = 1'b0;
    void'($urandom(76411));
    run_tests();
    total = local_errors + u_checker.errors;
    $display("Tests run %0d, failed %0d, errors %0d, popped %0d, credits %0d",
             tests_run, tests_failed, total, u_checker.pops, u_checker.credits_seen);
    if (timed_out || total != 0 || tests_failed != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/fifo_geom_pkg.sv
src/fifo_flow_pkg.sv
src/fifo_ram.sv
src/fifo_push_ctrl.sv
src/fifo_pop_ctrl.sv
src/fifo_credit_top.sv
sim/fifo_checker.sv
sim/fifo_tb.sv
